// ==== rtl/seg7_pkg.sv ====
package seg7_pkg;

  // --------------------
  // AXI4-Lite register map
  // --------------------
  localparam int ADDR_W = 4;
  localparam int DATA_W = 32;

  localparam logic [ADDR_W-1:0] REG_DATA_LO = 4'h0;
  localparam logic [ADDR_W-1:0] REG_DATA_HI = 4'h4;
  localparam logic [ADDR_W-1:0] REG_CTRL    = 4'h8;
  localparam logic [ADDR_W-1:0] REG_DIV     = 4'hC;

  localparam logic [1:0] RESP_OKAY   = 2'b00;
  localparam logic [1:0] RESP_DECERR = 2'b11;

  // --------------------
  // Display constants
  // --------------------
  localparam int NUM_DIGITS = 8;
  localparam int DIV_W      = 16;

  // Active low, all segments off.
  localparam logic [7:0]            SEG_BLANK = 8'hFF;
  localparam logic [NUM_DIGITS-1:0] SEL_NONE  = 8'hFF;

  // Hex font 0..F, active low, bit 7 is the decimal point.
  localparam logic [7:0] SEG_FONT [16] = '{
    8'hC0, 8'hF9, 8'hA4, 8'hB0, 8'h99, 8'h92, 8'h82, 8'hF8,
    8'h80, 8'h90, 8'h88, 8'h83, 8'hC6, 8'hA1, 8'h86, 8'h8E
  };

  typedef enum logic {DISP_HEX = 1'b0, DISP_RAW = 1'b1} disp_mode_e;
  typedef enum logic {W_IDLE, W_RESP} wr_state_e;
  typedef enum logic {R_IDLE, R_DATA} rd_state_e;

  typedef struct packed {
    logic [NUM_DIGITS*8-1:0] data;
    disp_mode_e              mode;
    logic                    enable;
    logic [DIV_W-1:0]        div;
  } seg7_cfg_t;

  typedef struct packed {
    logic [2:0] idx;
    logic [7:0] seg;
    logic       enable;
  } seg7_digit_t;

endpackage

// ==== rtl/seg7_axil_regs.sv ====
`timescale 1ns/1ns

module seg7_axil_regs (
  input  logic                          clk,
  input  logic                          rstn,
  input  logic                          i_awvalid,
  output logic                          o_awready,
  input  logic [seg7_pkg::ADDR_W-1:0]   i_awaddr,
  input  logic                          i_wvalid,
  output logic                          o_wready,
  input  logic [seg7_pkg::DATA_W-1:0]   i_wdata,
  input  logic [seg7_pkg::DATA_W/8-1:0] i_wstrb,
  output logic                          o_bvalid,
  input  logic                          i_bready,
  output logic [1:0]                    o_bresp,
  input  logic                          i_arvalid,
  output logic                          o_arready,
  input  logic [seg7_pkg::ADDR_W-1:0]   i_araddr,
  output logic                          o_rvalid,
  input  logic                          i_rready,
  output logic [seg7_pkg::DATA_W-1:0]   o_rdata,
  output logic [1:0]                    o_rresp,
  output seg7_pkg::seg7_cfg_t           o_cfg
);

  seg7_pkg::wr_state_e          wr_state;
  seg7_pkg::rd_state_e          rd_state;
  seg7_pkg::seg7_cfg_t          cfg_q;
  logic                         wr_go;
  logic                         rd_go;
  logic [seg7_pkg::DATA_W-1:0]  wr_new;

  // Unused bits and unmapped addresses read as zero.
  function automatic logic [seg7_pkg::DATA_W-1:0] reg_word(
    input logic [seg7_pkg::ADDR_W-1:0] addr,
    input seg7_pkg::seg7_cfg_t         cfg
  );
    logic [seg7_pkg::DATA_W-1:0] w;
    w = '0;
    case (addr)
      seg7_pkg::REG_DATA_LO: w = cfg.data[seg7_pkg::DATA_W-1:0];
      seg7_pkg::REG_DATA_HI: w = cfg.data[2*seg7_pkg::DATA_W-1:seg7_pkg::DATA_W];
      seg7_pkg::REG_CTRL: begin
        w[0] = cfg.mode;
        w[1] = cfg.enable;
      end
      seg7_pkg::REG_DIV: w[seg7_pkg::DIV_W-1:0] = cfg.div;
      default: w = '0;
    endcase
    return w;
  endfunction

  function automatic logic addr_hit(input logic [seg7_pkg::ADDR_W-1:0] addr);
    return (addr == seg7_pkg::REG_DATA_LO) || (addr == seg7_pkg::REG_DATA_HI) ||
           (addr == seg7_pkg::REG_CTRL) || (addr == seg7_pkg::REG_DIV);
  endfunction

  function automatic logic [seg7_pkg::DATA_W-1:0] apply_strb(
    input logic [seg7_pkg::DATA_W-1:0]   old,
    input logic [seg7_pkg::DATA_W-1:0]   wdata,
    input logic [seg7_pkg::DATA_W/8-1:0] strb
  );
    logic [seg7_pkg::DATA_W-1:0] w;
    w = old;
    for (int b = 0; b < seg7_pkg::DATA_W/8; b++) begin
      if (strb[b])
        w[8*b +: 8] = wdata[8*b +: 8];
    end
    return w;
  endfunction

  // --------------------
  // Write channel
  // --------------------
  assign wr_go     = (wr_state == seg7_pkg::W_IDLE) && i_awvalid && i_wvalid;
  assign o_awready = wr_go;
  assign o_wready  = wr_go;
  assign o_bvalid  = (wr_state == seg7_pkg::W_RESP);
  assign wr_new    = apply_strb(reg_word(i_awaddr, cfg_q), i_wdata, i_wstrb);

  always_ff @(posedge clk or negedge rstn) begin
    if (!rstn) begin
      wr_state <= seg7_pkg::W_IDLE;
      cfg_q    <= '0;
    end else begin
      if (wr_go) begin
        wr_state <= seg7_pkg::W_RESP;
        case (i_awaddr)
          seg7_pkg::REG_DATA_LO: cfg_q.data[seg7_pkg::DATA_W-1:0] <= wr_new;
          seg7_pkg::REG_DATA_HI:
            cfg_q.data[2*seg7_pkg::DATA_W-1:seg7_pkg::DATA_W] <= wr_new;
          seg7_pkg::REG_CTRL: begin
            cfg_q.mode   <= seg7_pkg::disp_mode_e'(wr_new[0]);
            cfg_q.enable <= wr_new[1];
          end
          seg7_pkg::REG_DIV: cfg_q.div <= wr_new[seg7_pkg::DIV_W-1:0];
          default: ;
        endcase
      end else if (o_bvalid && i_bready) begin
        wr_state <= seg7_pkg::W_IDLE;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (wr_go)
      o_bresp <= addr_hit(i_awaddr) ? seg7_pkg::RESP_OKAY : seg7_pkg::RESP_DECERR;
  end

  // --------------------
  // Read channel
  // --------------------
  assign rd_go     = (rd_state == seg7_pkg::R_IDLE) && i_arvalid;
  assign o_arready = (rd_state == seg7_pkg::R_IDLE);
  assign o_rvalid  = (rd_state == seg7_pkg::R_DATA);

  always_ff @(posedge clk or negedge rstn) begin
    if (!rstn)
      rd_state <= seg7_pkg::R_IDLE;
    else if (rd_go)
      rd_state <= seg7_pkg::R_DATA;
    else if (o_rvalid && i_rready)
      rd_state <= seg7_pkg::R_IDLE;
  end

  always_ff @(posedge clk) begin
    if (rd_go) begin
      o_rdata <= reg_word(i_araddr, cfg_q);
      o_rresp <= addr_hit(i_araddr) ? seg7_pkg::RESP_OKAY : seg7_pkg::RESP_DECERR;
    end
  end

  assign o_cfg = cfg_q;

  a_bvalid_hold: assert property (@(posedge clk) disable iff (!rstn)
    o_bvalid && !i_bready |=> o_bvalid);

  a_rdata_stable: assert property (@(posedge clk) disable iff (!rstn)
    o_rvalid && !i_rready |=> o_rvalid && $stable(o_rdata) && $stable(o_rresp));

endmodule

// ==== rtl/seg7_scanner.sv ====
`timescale 1ns/1ns

module seg7_scanner (
  input  logic                  clk,
  input  logic                  rstn,
  input  seg7_pkg::seg7_cfg_t   i_cfg,
  output seg7_pkg::seg7_digit_t o_digit
);

  logic [seg7_pkg::DIV_W-1:0] cnt;
  logic [2:0]                 idx;
  logic                       tick;
  logic [3:0]                 nib;
  logic [7:0]                 raw;
  logic [7:0]                 seg_next;

  // --------------------
  // Prescaler and digit counter
  // --------------------

  // Compare with >= so a smaller divider written mid-count takes effect at once.
  assign tick = (cnt >= i_cfg.div);

  always_ff @(posedge clk or negedge rstn) begin
    if (!rstn) begin
      cnt <= '0;
      idx <= '0;
    end else if (tick) begin
      cnt <= '0;
      idx <= idx + 3'd1;
    end else begin
      cnt <= cnt + 1'b1;
    end
  end

  // --------------------
  // Field select and decode
  // --------------------
  assign nib = i_cfg.data[{idx, 2'b00} +: 4];
  assign raw = i_cfg.data[{idx, 3'b000} +: 8];

  always_comb begin
    if (i_cfg.mode == seg7_pkg::DISP_HEX)
      seg_next = seg7_pkg::SEG_FONT[nib];
    else
      seg_next = raw;
  end

  // Digit record for the driver.
  always_ff @(posedge clk or negedge rstn) begin
    if (!rstn) begin
      o_digit.idx    <= '0;
      o_digit.seg    <= seg7_pkg::SEG_BLANK;
      o_digit.enable <= 1'b0;
    end else begin
      o_digit.idx    <= idx;
      o_digit.seg    <= seg_next;
      o_digit.enable <= i_cfg.enable;
    end
  end

endmodule

// ==== rtl/seg7_driver.sv ====
`timescale 1ns/1ns

module seg7_driver (
  input  logic                              clk,
  input  logic                              rstn,
  input  seg7_pkg::seg7_digit_t             i_digit,
  output logic [seg7_pkg::NUM_DIGITS-1:0]   o_sel,
  output logic [7:0]                        o_seg
);

  logic [2:0]                        last_idx;
  logic                              show;
  logic [seg7_pkg::NUM_DIGITS-1:0]   sel_dec;

  // One dark cycle on every digit change against ghosting.
  assign show = i_digit.enable && (i_digit.idx == last_idx);

  always_comb begin
    sel_dec              = seg7_pkg::SEL_NONE;
    sel_dec[i_digit.idx] = 1'b0;
  end

  always_ff @(posedge clk or negedge rstn) begin
    if (!rstn) begin
      last_idx <= '0;
      o_sel    <= seg7_pkg::SEL_NONE;
      o_seg    <= seg7_pkg::SEG_BLANK;
    end else begin
      last_idx <= i_digit.idx;
      if (show) begin
        o_sel <= sel_dec;
        o_seg <= i_digit.seg;
      end else begin
        o_sel <= seg7_pkg::SEL_NONE;
        o_seg <= seg7_pkg::SEG_BLANK;
      end
    end
  end

  // At most one digit driven.
  a_sel_onehot: assert property (@(posedge clk) disable iff (!rstn)
    $countones(~o_sel) <= 1);

endmodule

// ==== rtl/seg7_top.sv ====
`timescale 1ns/1ns

module seg7_top (
  input  logic                            clk,
  input  logic                            rstn,
  input  logic                            i_awvalid,
  output logic                            o_awready,
  input  logic [seg7_pkg::ADDR_W-1:0]     i_awaddr,
  input  logic                            i_wvalid,
  output logic                            o_wready,
  input  logic [seg7_pkg::DATA_W-1:0]     i_wdata,
  input  logic [seg7_pkg::DATA_W/8-1:0]   i_wstrb,
  output logic                            o_bvalid,
  input  logic                            i_bready,
  output logic [1:0]                      o_bresp,
  input  logic                            i_arvalid,
  output logic                            o_arready,
  input  logic [seg7_pkg::ADDR_W-1:0]     i_araddr,
  output logic                            o_rvalid,
  input  logic                            i_rready,
  output logic [seg7_pkg::DATA_W-1:0]     o_rdata,
  output logic [1:0]                      o_rresp,
  output logic [seg7_pkg::NUM_DIGITS-1:0] o_sel,
  output logic [7:0]                      o_seg
);

  seg7_pkg::seg7_cfg_t   cfg;
  seg7_pkg::seg7_digit_t digit;

  seg7_axil_regs i_seg7_axil_regs (
    .clk       (clk),
    .rstn      (rstn),
    .i_awvalid (i_awvalid),
    .o_awready (o_awready),
    .i_awaddr  (i_awaddr),
    .i_wvalid  (i_wvalid),
    .o_wready  (o_wready),
    .i_wdata   (i_wdata),
    .i_wstrb   (i_wstrb),
    .o_bvalid  (o_bvalid),
    .i_bready  (i_bready),
    .o_bresp   (o_bresp),
    .i_arvalid (i_arvalid),
    .o_arready (o_arready),
    .i_araddr  (i_araddr),
    .o_rvalid  (o_rvalid),
    .i_rready  (i_rready),
    .o_rdata   (o_rdata),
    .o_rresp   (o_rresp),
    .o_cfg     (cfg)
  );

  seg7_scanner i_seg7_scanner (
    .clk     (clk),
    .rstn    (rstn),
    .i_cfg   (cfg),
    .o_digit (digit)
  );

  seg7_driver i_seg7_driver (
    .clk     (clk),
    .rstn    (rstn),
    .i_digit (digit),
    .o_sel   (o_sel),
    .o_seg   (o_seg)
  );

endmodule

// ==== verif/seg7_tb.sv ====
`timescale 1ns/1ns

module seg7_tb;

  // Register rounds, scan phases at the largest divider, then margin.
  localparam int MAX_CYCLES = 20 * 12 + 6 * 8 * (7 + 2) * 2 + 500;

  localparam logic [7:0] FONT [16] = '{
    8'hC0, 8'hF9, 8'hA4, 8'hB0, 8'h99, 8'h92, 8'h82, 8'hF8,
    8'h80, 8'h90, 8'h88, 8'h83, 8'hC6, 8'hA1, 8'h86, 8'h8E
  };

  logic        clk = 1'b0;
  logic        rstn;
  logic        awvalid, awready, wvalid, wready, bvalid, bready;
  logic        arvalid, arready, rvalid, rready;
  logic [3:0]  awaddr, araddr, wstrb;
  logic [31:0] wdata, rdata;
  logic [1:0]  bresp, rresp;
  logic [7:0]  sel, seg;
  logic [31:0] model_regs [4];
  integer      seed;
  int          cycle_cnt = 0;

  always #10 clk = ~clk;

  seg7_top i_seg7_top (
    .clk       (clk),
    .rstn      (rstn),
    .i_awvalid (awvalid),
    .o_awready (awready),
    .i_awaddr  (awaddr),
    .i_wvalid  (wvalid),
    .o_wready  (wready),
    .i_wdata   (wdata),
    .i_wstrb   (wstrb),
    .o_bvalid  (bvalid),
    .i_bready  (bready),
    .o_bresp   (bresp),
    .i_arvalid (arvalid),
    .o_arready (arready),
    .i_araddr  (araddr),
    .o_rvalid  (rvalid),
    .i_rready  (rready),
    .o_rdata   (rdata),
    .o_rresp   (rresp),
    .o_sel     (sel),
    .o_seg     (seg)
  );

  task automatic stop_run(input string msg);
    $display("%s", msg);
    $display("Done: errors found");
    $fatal(1);
  endtask

  task automatic check_val(input string name, input logic [63:0] got, input logic [63:0] exp);
    if (got !== exp)
      stop_run($sformatf("** Error: %s got 0x%0h, expected 0x%0h", name, got, exp));
  endtask

  always @(posedge clk) begin
    cycle_cnt++;
    if (cycle_cnt >= MAX_CYCLES)
      stop_run("Timeout: the test did not finish within the cycle limit.");
  end

  // Inputs change and outputs are sampled here.
  task automatic step();
    @(posedge clk);
    #2;
  endtask

  // --------------------
  // AXI4-Lite tasks
  // --------------------
  task automatic axi_write(input logic [3:0] addr, input logic [31:0] data,
                           input logic [3:0] strb, output logic [1:0] resp);
    int dly;
    awaddr  = addr;
    wdata   = data;
    wstrb   = strb;
    awvalid = 1'b1;
    wvalid  = 1'b1;
    @(negedge clk);
    while (!(awready && wready))
      @(negedge clk);
    step();
    awvalid = 1'b0;
    wvalid  = 1'b0;
    dly = int'({$random(seed)} % 4);
    repeat (dly) step();
    bready = 1'b1;
    @(negedge clk);
    while (!bvalid)
      @(negedge clk);
    resp = bresp;
    step();
    bready = 1'b0;
  endtask

  task automatic axi_read(input logic [3:0] addr, output logic [31:0] data,
                          output logic [1:0] resp);
    int dly;
    araddr  = addr;
    arvalid = 1'b1;
    @(negedge clk);
    while (!arready)
      @(negedge clk);
    step();
    arvalid = 1'b0;
    dly = int'({$random(seed)} % 4);
    repeat (dly) step();
    rready = 1'b1;
    @(negedge clk);
    while (!rvalid)
      @(negedge clk);
    data = rdata;
    resp = rresp;
    step();
    rready = 1'b0;
  endtask

  // Model merge under strobes, then clip to the defined bits.
  task automatic write_check(input logic [3:0] addr, input logic [31:0] data,
                             input logic [3:0] strb);
    logic [1:0] resp;
    int         r;
    axi_write(addr, data, strb, resp);
    r = int'(addr[3:2]);
    if (addr[1:0] == 2'b00) begin
      for (int b = 0; b < 4; b++)
        if (strb[b])
          model_regs[r][8*b +: 8] = data[8*b +: 8];
      if (r == 2)
        model_regs[r] &= 32'h0000_0003;
      else if (r == 3)
        model_regs[r] &= 32'h0000_FFFF;
    end
    check_val($sformatf("bresp[%h]", addr), resp, (addr[1:0] == 2'b00) ? 2'b00 : 2'b11);
  endtask

  task automatic read_check(input logic [3:0] addr);
    logic [31:0] data;
    logic [1:0]  resp;
    axi_read(addr, data, resp);
    if (addr[1:0] == 2'b00) begin
      check_val($sformatf("rdata[%h]", addr), data, model_regs[addr[3:2]]);
      check_val($sformatf("rresp[%h]", addr), resp, 2'b00);
    end else begin
      check_val($sformatf("rdata[%h]", addr), data, 32'h0);
      check_val($sformatf("rresp[%h]", addr), resp, 2'b11);
    end
  endtask

  // --------------------
  // Display checks
  // --------------------
  task automatic monitor_scan(input int n_cycles);
    logic [63:0] data;
    logic [7:0]  seen;
    logic [7:0]  exp_seg;
    logic        gap;
    int          k;
    int          last_lit;
    data     = {model_regs[1], model_regs[0]};
    seen     = 8'h00;
    gap      = 1'b1;
    last_lit = -1;
    for (int c = 0; c < n_cycles; c++) begin
      step();
      k = 0;
      if (sel == 8'hFF) begin
        gap = 1'b1;
        check_val("o_seg", seg, 8'hFF);
      end else begin
        check_val("o_sel low bits", $countones(~sel), 1);
        for (int i = 0; i < 8; i++)
          if (!sel[i])
            k = i;
        // First sample may still carry the old config.
        if (c > 0) begin
          exp_seg = model_regs[2][0] ? data[8*k +: 8] : FONT[data[4*k +: 4]];
          check_val($sformatf("o_seg digit %0d", k), seg, exp_seg);
          seen[k] = 1'b1;
        end
        if (last_lit >= 0 && k != last_lit && !gap)
          stop_run($sformatf("Digits %0d and %0d lit with no blank cycle between.",
                             last_lit, k));
        last_lit = k;
        gap      = 1'b0;
      end
    end
    check_val("digits seen", seen, 8'hFF);
  endtask

  task automatic monitor_dark(input int n_cycles, input int dark_from);
    for (int c = 1; c <= n_cycles; c++) begin
      step();
      if (c >= dark_from) begin
        check_val("o_sel", sel, 8'hFF);
        check_val("o_seg", seg, 8'hFF);
      end
    end
  endtask

  // --------------------
  // Test sequence
  // --------------------
  initial begin
    logic [3:0] addr;
    int         div;
    awvalid = 1'b0;
    awaddr  = '0;
    wvalid  = 1'b0;
    wdata   = '0;
    wstrb   = '0;
    bready  = 1'b0;
    arvalid = 1'b0;
    araddr  = '0;
    rready  = 1'b0;
    rstn    = 1'b0;
    seed    = 32'h5a70;
    div     = 0;
    for (int r = 0; r < 4; r++)
      model_regs[r] = '0;
    repeat (3) @(posedge clk);
    #2;
    rstn = 1'b1;

    check_val("o_sel", sel, 8'hFF);
    check_val("o_seg", seg, 8'hFF);
    check_val("o_awready", awready, 1'b0);
    check_val("o_wready", wready, 1'b0);
    check_val("o_bvalid", bvalid, 1'b0);
    check_val("o_arready", arready, 1'b1);
    check_val("o_rvalid", rvalid, 1'b0);
    for (int r = 0; r < 4; r++)
      read_check(4'(r * 4));

    // Each mapped register twice, random data and strobes.
    for (int n = 0; n < 8; n++) begin
      addr = {2'(n), 2'b00};
      write_check(addr, $random(seed), 4'($random(seed)));
      read_check(addr);
    end
    // Unmapped address, no side effects.
    addr = 4'($random(seed));
    if (addr[1:0] == 2'b00)
      addr[0] = 1'b1;
    write_check(addr, $random(seed), 4'hF);
    read_check(addr);
    for (int r = 0; r < 4; r++)
      read_check(4'(r * 4));

    // Alternate hex and raw mode.
    for (int p = 0; p < 5; p++) begin
      div = 1 + int'({$random(seed)} % 7);
      write_check(seg7_pkg::REG_DATA_LO, $random(seed), 4'hF);
      write_check(seg7_pkg::REG_DATA_HI, $random(seed), 4'hF);
      write_check(seg7_pkg::REG_DIV, 32'(div), 4'hF);
      write_check(seg7_pkg::REG_CTRL, {30'd0, 1'b1, p[0]}, 4'hF);
      monitor_scan(2 * 8 * (div + 1));
    end

    write_check(seg7_pkg::REG_CTRL, 32'h0, 4'hF);
    monitor_dark(2 * 8 * (div + 1), 2 * (div + 1) + 2);

    $display("Done: no errors");
    $finish;
  end

endmodule

// ==== vlog.f ====
rtl/seg7_pkg.sv
rtl/seg7_axil_regs.sv
rtl/seg7_scanner.sv
rtl/seg7_driver.sv
rtl/seg7_top.sv
verif/seg7_tb.sv

// ==== Makefile ====
SRCS = rtl/seg7_pkg.sv rtl/seg7_axil_regs.sv rtl/seg7_scanner.sv \
       rtl/seg7_driver.sv rtl/seg7_top.sv verif/seg7_tb.sv

.PHONY: all run clean

all: run

obj_dir/Vseg7_tb: vlog.f $(SRCS)
	verilator --binary --timing --assert -Wno-fatal --top-module seg7_tb \
	  -f vlog.f -o Vseg7_tb

run: obj_dir/Vseg7_tb
	./obj_dir/Vseg7_tb

clean:
	rm -rf obj_dir
